// ==== Makefile ====
VERILATOR ?= verilator
TOP       := bsg_chip_top_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP)
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

# Exit status comes from the search for the pass line.
test:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
+incdir+src
src/chip_pkg.sv
src/bsg_tag_master.sv
src/bsg_tag_client.sv
src/bsg_chip_core_complex.sv
src/bsg_chip_top.sv
verification/bsg_chip_top_checker.sv
verification/bsg_chip_top_tb.sv

// ==== src/bsg_chip_core_complex.sv ====
`timescale 1ns/1ps
`include "chip_params.svh"

module bsg_chip_core_complex
  (input                                                        hb_clk_i
  ,input                                                        rst_n_i

  ,input                                                        tag_v_i
  ,input  chip_pkg::tag_id_t                                    tag_id_i
  ,input  chip_pkg::tag_payload_t                               tag_data_i

  ,input  chip_pkg::io_link_t  [`CHIP_IO_LINK_NUM-1:0]          io_links_i
  ,output chip_pkg::io_link_t  [`CHIP_IO_LINK_NUM-1:0]          io_links_o

  ,input  chip_pkg::mem_link_t [`CHIP_MEM_LINK_NUM-1:0]         mem_links_i
  ,output chip_pkg::mem_link_t [`CHIP_MEM_LINK_NUM-1:0]         mem_links_o

  ,output logic                                                 hb_reset_o
  ,output chip_pkg::hb_dest_cord_tag_payload_s [1:0]            hb_dest_cord_o
  ,output logic [1:0]                                           hb_cord_new_o
  );

  // ####################################################################
  // Tag clients
  // ####################################################################

  chip_pkg::hb_tag_payload_s hb_tag_data_lo;

  // New-data pulse of the reset client is not needed.
  bsg_tag_client #(.payload_t(chip_pkg::hb_tag_payload_s), .id_p(`CHIP_TAG_ID_HB_RESET))
    btc_hb
      (.hb_clk_i      (hb_clk_i)
      ,.rst_n_i       (rst_n_i)
      ,.tag_v_i       (tag_v_i)
      ,.tag_id_i      (tag_id_i)
      ,.tag_data_i    (tag_data_i)
      ,.recv_data_r_o (hb_tag_data_lo)
      ,.recv_new_r_o  ()
      );

  assign hb_reset_o = hb_tag_data_lo.reset;

  for (genvar i = 0; i < 2; i++)
  begin: hb_cord_loop
    bsg_tag_client
      #(.payload_t (chip_pkg::hb_dest_cord_tag_payload_s)
       ,.id_p      ((i == 0) ? `CHIP_TAG_ID_CORD0 : `CHIP_TAG_ID_CORD1)
       )
      btc_hb_dest_cord
        (.hb_clk_i      (hb_clk_i)
        ,.rst_n_i       (rst_n_i)
        ,.tag_v_i       (tag_v_i)
        ,.tag_id_i      (tag_id_i)
        ,.tag_data_i    (tag_data_i)
        ,.recv_data_r_o (hb_dest_cord_o[i])
        ,.recv_new_r_o  (hb_cord_new_o[i])
        );
  end

  // ####################################################################
  // Loopback
  // ####################################################################

  // Zeros loaded while the core sits in reset.
  always_ff @(posedge hb_clk_i)
  begin
    if (!rst_n_i || hb_reset_o)
    begin
      io_links_o  <= '0;
      mem_links_o <= '0;
    end
    else
    begin
      io_links_o  <= io_links_i;
      mem_links_o <= mem_links_i;
    end
  end

endmodule

// ==== src/bsg_chip_top.sv ====
`timescale 1ns/1ps
`include "chip_params.svh"

module bsg_chip_top
  (input                                                hb_clk_i
  ,input                                                rst_n_i

  ,input                                                tag_en_i
  ,input                                                tag_data_i

  ,input  chip_pkg::io_link_t  [`CHIP_IO_LINK_NUM-1:0]  io_links_i
  ,output chip_pkg::io_link_t  [`CHIP_IO_LINK_NUM-1:0]  io_links_o
  ,input  chip_pkg::mem_link_t [`CHIP_MEM_LINK_NUM-1:0] mem_links_i
  ,output chip_pkg::mem_link_t [`CHIP_MEM_LINK_NUM-1:0] mem_links_o

  ,output logic                                         hb_reset_o
  ,output chip_pkg::hb_dest_cord_tag_payload_s [1:0]    hb_dest_cord_o
  ,output logic [1:0]                                   hb_cord_new_o
  );

  // Strobe from master to the clients.
  logic                   tag_v;
  chip_pkg::tag_id_t      tag_id;
  chip_pkg::tag_payload_t tag_data;

  bsg_tag_master tag_master
    (.hb_clk_i   (hb_clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.tag_en_i   (tag_en_i)
    ,.tag_data_i (tag_data_i)
    ,.tag_v_o    (tag_v)
    ,.tag_id_o   (tag_id)
    ,.tag_data_o (tag_data)
    );

  bsg_chip_core_complex core_complex
    (.hb_clk_i       (hb_clk_i)
    ,.rst_n_i        (rst_n_i)
    ,.tag_v_i        (tag_v)
    ,.tag_id_i       (tag_id)
    ,.tag_data_i     (tag_data)
    ,.io_links_i     (io_links_i)
    ,.io_links_o     (io_links_o)
    ,.mem_links_i    (mem_links_i)
    ,.mem_links_o    (mem_links_o)
    ,.hb_reset_o     (hb_reset_o)
    ,.hb_dest_cord_o (hb_dest_cord_o)
    ,.hb_cord_new_o  (hb_cord_new_o)
    );

endmodule

// ==== src/bsg_tag_client.sv ====
`timescale 1ns/1ps

module bsg_tag_client
  #(parameter type payload_t = chip_pkg::tag_payload_t
   ,parameter int  id_p      = 0
   )
  (input                         hb_clk_i
  ,input                         rst_n_i

  ,input                         tag_v_i
  ,input chip_pkg::tag_id_t      tag_id_i
  ,input chip_pkg::tag_payload_t tag_data_i

  ,output payload_t              recv_data_r_o
  ,output logic                  recv_new_r_o
  );

  localparam int payload_w_lp = $bits(payload_t);

  logic match;

  // Strobe addressed to this client.
  assign match = tag_v_i && (tag_id_i == chip_pkg::tag_id_t'(id_p));

  always_ff @(posedge hb_clk_i)
  begin
    if (!rst_n_i)
    begin
      recv_data_r_o <= '0;
      recv_new_r_o  <= 1'b0;
    end
    else
    begin
      recv_new_r_o <= match;
      // Payload struct takes the low bits of the frame.
      if (match)
        recv_data_r_o <= payload_t'(tag_data_i[payload_w_lp-1:0]);
    end
  end

endmodule

// ==== src/bsg_tag_master.sv ====
`timescale 1ns/1ps
`include "chip_params.svh"

module bsg_tag_master
  (input                         hb_clk_i
  ,input                         rst_n_i

  ,input                         tag_en_i
  ,input                         tag_data_i

  ,output logic                  tag_v_o
  ,output chip_pkg::tag_id_t      tag_id_o
  ,output chip_pkg::tag_payload_t tag_data_o
  );

  // Id bits then payload bits follow the start bit.
  localparam int frame_w_lp = `CHIP_TAG_ID_W + `CHIP_TAG_PAYLOAD_W;
  localparam int cnt_w_lp   = $clog2(frame_w_lp);

  logic                  busy_r;  // Inside a frame.
  logic [cnt_w_lp-1:0]   cnt_r;   // Bits taken so far.
  logic                  done_r;  // Last bit taken last edge.
  logic [frame_w_lp-1:0] shift_r;
  logic                  last_bit;

  assign last_bit = (cnt_r == cnt_w_lp'(frame_w_lp-1));

  // ####################################################################
  // Frame control
  // ####################################################################

  always_ff @(posedge hb_clk_i)
  begin
    if (!rst_n_i)
    begin
      busy_r  <= 1'b0;
      cnt_r   <= '0;
      done_r  <= 1'b0;
      tag_v_o <= 1'b0;
    end
    else
    begin
      done_r  <= 1'b0;
      tag_v_o <= done_r; // One cycle strobe.
      if (tag_en_i)
      begin
        if (!busy_r)
        begin
          // Idle zeros are dropped, a one starts the frame.
          if (tag_data_i)
          begin
            busy_r <= 1'b1;
            cnt_r  <= '0;
          end
        end
        else
        begin
          cnt_r <= cnt_r + cnt_w_lp'(1);
          if (last_bit)
          begin
            busy_r <= 1'b0;
            done_r <= 1'b1;
          end
        end
      end
    end
  end

  // ####################################################################
  // Frame data
  // ####################################################################

  // MSB first, so shift in from the bottom.
  always_ff @(posedge hb_clk_i)
  begin
    if (tag_en_i && busy_r)
      shift_r <= {shift_r[frame_w_lp-2:0], tag_data_i};
  end

  always_ff @(posedge hb_clk_i)
  begin
    if (done_r)
      {tag_id_o, tag_data_o} <= shift_r; // Held until the next frame.
  end

endmodule

// ==== src/chip_params.svh ====
`ifndef CHIP_PARAMS_SVH
`define CHIP_PARAMS_SVH

// Tag frame fields.
`define CHIP_TAG_ID_W      2
`define CHIP_TAG_PAYLOAD_W 8

`define CHIP_CORD_W 7 // Destination coordinate.

// Link counts and word widths.
`define CHIP_IO_LINK_NUM  2
`define CHIP_IO_LINK_W    16
`define CHIP_MEM_LINK_NUM 2
`define CHIP_MEM_LINK_W   32

// Client addresses on the tag bus.
`define CHIP_TAG_ID_HB_RESET 0
`define CHIP_TAG_ID_CORD0    1
`define CHIP_TAG_ID_CORD1    2

`endif

// ==== src/chip_pkg.sv ====
`include "chip_params.svh"

package chip_pkg;

  // ####################################################################
  // Tag bus types
  // ####################################################################

  typedef logic [`CHIP_TAG_ID_W-1:0]      tag_id_t;
  typedef logic [`CHIP_TAG_PAYLOAD_W-1:0] tag_payload_t;

  // hb control payload, sits in the low bits of a frame.
  typedef struct packed
  {
    logic padding;
    logic reset; // Core held in reset when set.
  } hb_tag_payload_s;

  // hb destination coordinate payload.
  typedef struct packed
  {
    logic [`CHIP_CORD_W-1:0] cord;
  } hb_dest_cord_tag_payload_s;

  // ####################################################################
  // Link words
  // ####################################################################

  typedef logic [`CHIP_IO_LINK_W-1:0]  io_link_t;  // One I/O link.
  typedef logic [`CHIP_MEM_LINK_W-1:0] mem_link_t; // One memory link.

endpackage

// ==== verification/bsg_chip_top_checker.sv ====
`timescale 1ns/1ps
`include "chip_params.svh"

module bsg_chip_top_checker
  (input                                               hb_clk_i
  ,input                                               rst_n_i
  ,input chip_pkg::io_link_t  [`CHIP_IO_LINK_NUM-1:0]  io_out_i
  ,input chip_pkg::mem_link_t [`CHIP_MEM_LINK_NUM-1:0] mem_out_i
  ,input                                               hb_reset_i
  ,input chip_pkg::hb_dest_cord_tag_payload_s [1:0]    hb_cord_i
  ,input logic [1:0]                                   hb_cord_new_i
  );

  int assert_fail_cnt = 0; // Read back by the testbench summary.

  // ####################################################################
  // Strobes and reset state
  // ####################################################################

  cord0_pulse_short: assert property (@(posedge hb_clk_i) disable iff (!rst_n_i)
    hb_cord_new_i[0] |=> !hb_cord_new_i[0])
    else
    begin
      $error("cord0 new-data pulse longer than one cycle");
      assert_fail_cnt++;
    end

  cord1_pulse_short: assert property (@(posedge hb_clk_i) disable iff (!rst_n_i)
    hb_cord_new_i[1] |=> !hb_cord_new_i[1])
    else
    begin
      $error("cord1 new-data pulse longer than one cycle");
      assert_fail_cnt++;
    end

  reset_outputs_zero: assert property (@(posedge hb_clk_i)
    !rst_n_i |=> (!hb_reset_i && hb_cord_i == '0 && hb_cord_new_i == 2'b00
                  && io_out_i == '0 && mem_out_i == '0))
    else
    begin
      $error("outputs not zero after reset");
      assert_fail_cnt++;
    end

  // Core reset gates the loopback.
  links_gated: assert property (@(posedge hb_clk_i)
    hb_reset_i |=> (io_out_i == '0 && mem_out_i == '0))
    else
    begin
      $error("links not zero while hb reset set");
      assert_fail_cnt++;
    end

endmodule

// ==== verification/bsg_chip_top_tb.sv ====
`timescale 1ns/1ps
`include "chip_params.svh"

module bsg_chip_top_tb;

  localparam int kind_idle_lp  = 0; // Compare only.
  localparam int kind_link_lp  = 1;
  localparam int kind_frame_lp = 2;
  localparam int kind_gaps_lp  = 3; // Frame with enable gaps and idle zeros.

  logic clk;
  logic rst_n;
  logic tag_en;
  logic tag_data;
  chip_pkg::io_link_t  [`CHIP_IO_LINK_NUM-1:0]  io_in;
  chip_pkg::io_link_t  [`CHIP_IO_LINK_NUM-1:0]  io_out;
  chip_pkg::mem_link_t [`CHIP_MEM_LINK_NUM-1:0] mem_in;
  chip_pkg::mem_link_t [`CHIP_MEM_LINK_NUM-1:0] mem_out;
  logic                                         hb_reset;
  chip_pkg::hb_dest_cord_tag_payload_s [1:0]    hb_cord;
  logic [1:0]                                   hb_cord_new;

  // Stimulus table with one entry per row in each queue.
  string                   row_name[$];
  int                      row_kind[$];
  chip_pkg::tag_id_t       row_id[$];
  chip_pkg::tag_payload_t  row_payload[$];
  logic                    row_reset[$];
  logic [`CHIP_CORD_W-1:0] row_cord0[$];
  logic [`CHIP_CORD_W-1:0] row_cord1[$];

  int error_cnt   = 0;
  int fail_tests  = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;

  bsg_chip_top DUT
    (.hb_clk_i (clk), .rst_n_i (rst_n), .tag_en_i (tag_en), .tag_data_i (tag_data)
    ,.io_links_i (io_in), .io_links_o (io_out), .mem_links_i (mem_in), .mem_links_o (mem_out)
    ,.hb_reset_o (hb_reset), .hb_dest_cord_o (hb_cord), .hb_cord_new_o (hb_cord_new)
    );

  bind bsg_chip_top bsg_chip_top_checker checker_i
    (.hb_clk_i (hb_clk_i), .rst_n_i (rst_n_i), .io_out_i (io_links_o)
    ,.mem_out_i (mem_links_o), .hb_reset_i (hb_reset_o), .hb_cord_i (hb_dest_cord_o)
    ,.hb_cord_new_i (hb_cord_new_o)
    );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: tests did not complete within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  // ####################################################################
  // Compare tasks
  // ####################################################################

  task automatic check_logic(input string test, input string what, input logic exp,
                             input logic act);
    if (act !== exp)
    begin
      $display("Error %s: %s expected %0b actual %0b", test, what, exp, act);
      error_cnt++;
    end
  endtask

  task automatic check_cord(input string test, input string what,
                            input chip_pkg::hb_dest_cord_tag_payload_s exp,
                            input chip_pkg::hb_dest_cord_tag_payload_s act);
    if (act !== exp)
    begin
      $display("Error %s: %s expected %h actual %h", test, what, exp.cord, act.cord);
      error_cnt++;
    end
  endtask

  task automatic check_io(input string test, input chip_pkg::io_link_t exp,
                          input chip_pkg::io_link_t act);
    if (act !== exp)
    begin
      $display("Error %s: io link expected %h actual %h", test, exp, act);
      error_cnt++;
    end
  endtask

  task automatic check_mem(input string test, input chip_pkg::mem_link_t exp,
                           input chip_pkg::mem_link_t act);
    if (act !== exp)
    begin
      $display("Error %s: mem link expected %h actual %h", test, exp, act);
      error_cnt++;
    end
  endtask

  // ####################################################################
  // Stimulus
  // ####################################################################

  task automatic add_row(input string name, input int kind, input chip_pkg::tag_id_t id,
                         input chip_pkg::tag_payload_t payload, input logic rst,
                         input logic [`CHIP_CORD_W-1:0] cord0,
                         input logic [`CHIP_CORD_W-1:0] cord1);
    row_name.push_back(name);
    row_kind.push_back(kind);
    row_id.push_back(id);
    row_payload.push_back(payload);
    row_reset.push_back(rst);
    row_cord0.push_back(cord0);
    row_cord1.push_back(cord1);
  endtask

  task automatic drive_bit(input logic b, input bit gaps);
    if (gaps && ($urandom % 2 == 1))
    begin
      @(posedge clk);
      tag_en   <= 1'b0; // Gap cycle with junk on the line.
      tag_data <= 1'($urandom % 2);
    end
    @(posedge clk);
    tag_en   <= 1'b1;
    tag_data <= b;
  endtask

  task automatic run_frame(input string test, input chip_pkg::tag_id_t id,
                           input chip_pkg::tag_payload_t payload, input bit gaps);
    logic [`CHIP_TAG_ID_W+`CHIP_TAG_PAYLOAD_W:0] frame;
    logic [1:0] exp_new;
    int lead;
    int i;
    frame   = {1'b1, id, payload};
    exp_new = {id == chip_pkg::tag_id_t'(`CHIP_TAG_ID_CORD1),
               id == chip_pkg::tag_id_t'(`CHIP_TAG_ID_CORD0)};
    lead    = gaps ? 1 + int'($urandom % 3) : 0;
    for (i = 0; i < lead; i++)
      drive_bit(1'b0, gaps); // Idle zeros ahead of the start bit.
    for (i = $bits(frame) - 1; i >= 0; i--)
      drive_bit(frame[i], gaps);
    @(posedge clk); // Last bit sampled.
    tag_en <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_logic(test, "cord0 new early", 1'b0, hb_cord_new[0]);
    check_logic(test, "cord1 new early", 1'b0, hb_cord_new[1]);
    @(posedge clk); // Two edges after the last bit.
    @(negedge clk);
    check_logic(test, "cord0 new", exp_new[0], hb_cord_new[0]);
    check_logic(test, "cord1 new", exp_new[1], hb_cord_new[1]);
  endtask

  task automatic run_links(input string test, input logic in_reset);
    chip_pkg::io_link_t  [`CHIP_IO_LINK_NUM-1:0]  io_prev, io_next;
    chip_pkg::mem_link_t [`CHIP_MEM_LINK_NUM-1:0] mem_prev, mem_next;
    int w;
    int i;
    for (w = 0; w <= 4; w++)
    begin
      @(posedge clk);
      for (i = 0; i < `CHIP_IO_LINK_NUM; i++)
        io_next[i] = chip_pkg::io_link_t'($urandom);
      for (i = 0; i < `CHIP_MEM_LINK_NUM; i++)
        mem_next[i] = chip_pkg::mem_link_t'($urandom);
      io_in  <= io_next;
      mem_in <= mem_next;
      @(negedge clk);
      // Output shows the word driven one edge earlier.
      if (w > 0)
      begin
        for (i = 0; i < `CHIP_IO_LINK_NUM; i++)
          check_io(test, in_reset ? chip_pkg::io_link_t'(0) : io_prev[i], io_out[i]);
        for (i = 0; i < `CHIP_MEM_LINK_NUM; i++)
          check_mem(test, in_reset ? chip_pkg::mem_link_t'(0) : mem_prev[i], mem_out[i]);
      end
      io_prev  = io_next;
      mem_prev = mem_next;
    end
  endtask

  // ####################################################################
  // Test sequence
  // ####################################################################

  initial
  begin
    int r;
    int row_errs;
    int i;
    void'($urandom(32'h635a_e926));
    rst_n    = 1'b0;
    tag_en   = 1'b0;
    tag_data = 1'b0;
    for (i = 0; i < `CHIP_IO_LINK_NUM; i++)
      io_in[i] = chip_pkg::io_link_t'($urandom); // Nonzero during reset.
    for (i = 0; i < `CHIP_MEM_LINK_NUM; i++)
      mem_in[i] = chip_pkg::mem_link_t'($urandom);

    add_row("after_reset",    kind_idle_lp,  2'd0, 8'h00, 1'b0, 7'h00, 7'h00);
    add_row("link_loopback",  kind_link_lp,  2'd0, 8'h00, 1'b0, 7'h00, 7'h00);
    add_row("cord0_set",      kind_frame_lp, 2'd1, 8'hA5, 1'b0, 7'h25, 7'h00);
    add_row("cord1_set",      kind_frame_lp, 2'd2, 8'h3C, 1'b0, 7'h25, 7'h3C);
    add_row("hb_reset_set",   kind_frame_lp, 2'd0, 8'h01, 1'b1, 7'h25, 7'h3C);
    add_row("link_in_reset",  kind_link_lp,  2'd0, 8'h00, 1'b1, 7'h25, 7'h3C);
    add_row("hb_reset_clear", kind_frame_lp, 2'd0, 8'hFE, 1'b0, 7'h25, 7'h3C);
    add_row("link_restored",  kind_link_lp,  2'd0, 8'h00, 1'b0, 7'h25, 7'h3C);
    add_row("cord0_gaps",     kind_gaps_lp,  2'd1, 8'h7F, 1'b0, 7'h7F, 7'h3C);
    add_row("cord1_gaps",     kind_gaps_lp,  2'd2, 8'h80, 1'b0, 7'h7F, 7'h00);
    add_row("id3_ignored",    kind_frame_lp, 2'd3, 8'h55, 1'b0, 7'h7F, 7'h00);
    add_row("id3_gaps",       kind_gaps_lp,  2'd3, 8'hFF, 1'b0, 7'h7F, 7'h00);
    add_row("link_final",     kind_link_lp,  2'd0, 8'h00, 1'b0, 7'h7F, 7'h00);
    cycle_limit = row_name.size() * 40;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    for (r = 0; r < row_name.size(); r++)
    begin
      row_errs = error_cnt;
      case (row_kind[r])
        kind_idle_lp:
        begin
          @(negedge clk);
          check_logic(row_name[r], "cord new", 1'b0, |hb_cord_new);
          for (i = 0; i < `CHIP_IO_LINK_NUM; i++)
            check_io(row_name[r], chip_pkg::io_link_t'(0), io_out[i]);
          for (i = 0; i < `CHIP_MEM_LINK_NUM; i++)
            check_mem(row_name[r], chip_pkg::mem_link_t'(0), mem_out[i]);
        end
        kind_link_lp:  run_links(row_name[r], row_reset[r]);
        kind_frame_lp: run_frame(row_name[r], row_id[r], row_payload[r], 1'b0);
        kind_gaps_lp:  run_frame(row_name[r], row_id[r], row_payload[r], 1'b1);
        default:
        begin
          $display("Row %s has an unknown kind", row_name[r]);
          error_cnt++;
        end
      endcase
      check_logic(row_name[r], "hb_reset", row_reset[r], hb_reset);
      check_cord(row_name[r], "cord0", chip_pkg::hb_dest_cord_tag_payload_s'(row_cord0[r]),
                 hb_cord[0]);
      check_cord(row_name[r], "cord1", chip_pkg::hb_dest_cord_tag_payload_s'(row_cord1[r]),
                 hb_cord[1]);
      if (error_cnt != row_errs)
        fail_tests++;
      $display("Test %-14s %s", row_name[r], (error_cnt == row_errs) ? "ok" : "FAILED");
    end

    error_cnt += DUT.checker_i.assert_fail_cnt; // Assertion failures count too.
    $display("Tests: %0d run, %0d failed, %0d errors", row_name.size(), fail_tests, error_cnt);
    if (error_cnt == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
